/* design/cache_meta_pkg.sv */
/*
 * Field widths and types of the cache metadata.
 * Address split is tag, set index, block offset from high to low bits.
 */
`include "cache_miss_defines.svh"

`default_nettype none

package cache_meta_pkg;

  // byte offset inside one block.
  localparam int BLOCK_OFFSET_W = $clog2(`CM_BLOCK_WORDS * `CM_WORD_BYTES);
  localparam int INDEX_W = $clog2(`CM_SETS);
  localparam int TAG_W = `CM_ADDR_WIDTH - INDEX_W - BLOCK_OFFSET_W;
  localparam int WAY_ID_W = $clog2(`CM_WAYS);

  // one bit per internal node of the pseudo-LRU tree.
  localparam int LRU_W = `CM_WAYS - 1;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] set_idx_t;
  typedef logic [WAY_ID_W-1:0] way_id_t;
  typedef logic [`CM_WAYS-1:0] way_vec_t;

  // node 0 is the root and node n has children 2n+1 and 2n+2.
  // a 0 bit means the LRU side lies in the lower half.
  typedef logic [LRU_W-1:0] lru_bits_t;

  typedef tag_t [`CM_WAYS-1:0] tag_array_t;

endpackage

`default_nettype wire

/* design/cache_meta_store.sv */
/*
 * Per-set tag, valid, lock, dirty and LRU storage.
 * A read strobe latches one set onto the outputs in the next cycle.
 * Tag and stat writes are masked per way or per LRU node.
 */
`timescale 1ns/1ps
`include "cache_miss_defines.svh"
`default_nettype none

module cache_meta_store (
  input  wire                             clk_i,
  input  wire                             reset_i,
  input  wire                             rd_v_i,
  input  wire cache_meta_pkg::set_idx_t   set_i,
  input  wire                             tag_we_i,
  input  wire cache_meta_pkg::tag_t       tag_data_i,
  input  wire                             lock_data_i,
  input  wire                             valid_data_i,
  input  wire cache_meta_pkg::way_vec_t   tag_mask_i,
  input  wire cache_meta_pkg::way_vec_t   lock_mask_i,
  input  wire cache_meta_pkg::way_vec_t   valid_mask_i,
  input  wire                             stat_we_i,
  input  wire                             dirty_data_i,
  input  wire cache_meta_pkg::way_vec_t   dirty_mask_i,
  input  wire cache_meta_pkg::lru_bits_t  lru_data_i,
  input  wire cache_meta_pkg::lru_bits_t  lru_mask_i,
  output cache_meta_pkg::tag_array_t      tags_o,
  output cache_meta_pkg::way_vec_t        valid_o,
  output cache_meta_pkg::way_vec_t        lock_o,
  output cache_meta_pkg::way_vec_t        dirty_o,
  output cache_meta_pkg::lru_bits_t       lru_o
);
  import cache_meta_pkg::*;

  tag_array_t tag_mem [`CM_SETS];
  way_vec_t   valid_mem [`CM_SETS];
  way_vec_t   lock_mem [`CM_SETS];
  way_vec_t   dirty_mem [`CM_SETS];
  lru_bits_t  lru_mem [`CM_SETS];

  // tag array, written only in the ways named by the mask.
  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      for (int w = 0; w < `CM_WAYS; w++) begin
        if (tag_mask_i[w]) begin
          tag_mem[set_i][w] <= tag_data_i;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < `CM_SETS; s++) begin
        valid_mem[s] <= '0;
        lock_mem[s] <= '0;
        dirty_mem[s] <= '0;
        lru_mem[s] <= '0;
      end
    end else begin
      if (tag_we_i) begin
        valid_mem[set_i] <= (valid_mem[set_i] & ~valid_mask_i)
                          | ({`CM_WAYS{valid_data_i}} & valid_mask_i);
        lock_mem[set_i] <= (lock_mem[set_i] & ~lock_mask_i)
                         | ({`CM_WAYS{lock_data_i}} & lock_mask_i);
      end
      if (stat_we_i) begin
        dirty_mem[set_i] <= (dirty_mem[set_i] & ~dirty_mask_i)
                          | ({`CM_WAYS{dirty_data_i}} & dirty_mask_i);
        lru_mem[set_i] <= (lru_mem[set_i] & ~lru_mask_i) | (lru_data_i & lru_mask_i);
      end
    end
  end

  // registered read, held until the next read strobe.
  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      tags_o <= tag_mem[set_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= '0;
      lock_o <= '0;
      dirty_o <= '0;
      lru_o <= '0;
    end else if (rd_v_i) begin
      valid_o <= valid_mem[set_i];
      lock_o <= lock_mem[set_i];
      dirty_o <= dirty_mem[set_i];
      lru_o <= lru_mem[set_i];
    end
  end

  // the FSM shares one set index for reads and writes, so a write beside a read
  // would leave the lookup with the old contents of the same set.
  assert property (@(posedge clk_i) disable iff (reset_i)
    rd_v_i |-> !(tag_we_i || stat_we_i));

endmodule

`default_nettype wire

/* design/cache_miss_defines.svh */
/*
 * Geometry of the cache behind the miss handler.
 * Included by the metadata package and by modules that size arrays from it.
 */
`ifndef CACHE_MISS_DEFINES_SVH
`define CACHE_MISS_DEFINES_SVH

// width of a request address in bits.
`define CM_ADDR_WIDTH 32

// number of sets in the cache.
`define CM_SETS 16

// associativity, kept a power of two for the LRU tree.
`define CM_WAYS 4

`define CM_BLOCK_WORDS 8
`define CM_WORD_BYTES 4

`endif

/* design/cache_miss_fsm.sv */
/*
 * Miss handler state machine.
 * Accepts one request, looks up the set, then runs hit, flush, lock or
 * fill and evict sequences through DMA commands and metadata writes.
 */
`timescale 1ns/1ps
`include "cache_miss_defines.svh"
`default_nettype none

module cache_miss_fsm (
  input  wire                             clk_i,
  input  wire                             reset_i,
  input  wire                             req_v_i,
  input  wire cache_op_pkg::cache_op_e    req_op_i,
  input  wire [`CM_ADDR_WIDTH-1:0]        req_addr_i,
  input  wire                             hit_i,
  input  wire cache_meta_pkg::way_id_t    hit_way_i,
  input  wire cache_meta_pkg::way_id_t    victim_way_i,
  input  wire cache_meta_pkg::lru_bits_t  mru_data_i,
  input  wire cache_meta_pkg::lru_bits_t  mru_mask_i,
  input  wire cache_meta_pkg::tag_array_t tags_i,
  input  wire cache_meta_pkg::way_vec_t   valid_i,
  input  wire cache_meta_pkg::way_vec_t   dirty_i,
  input  wire                             dma_done_i,
  input  wire                             ack_i,
  output logic                            ready_o,
  output logic                            rd_v_o,
  output cache_meta_pkg::set_idx_t        set_o,
  output logic                            tag_we_o,
  output cache_meta_pkg::tag_t            tag_data_o,
  output logic                            lock_data_o,
  output logic                            valid_data_o,
  output cache_meta_pkg::way_vec_t        tag_mask_o,
  output cache_meta_pkg::way_vec_t        lock_mask_o,
  output cache_meta_pkg::way_vec_t        valid_mask_o,
  output logic                            stat_we_o,
  output logic                            dirty_data_o,
  output cache_meta_pkg::way_vec_t        dirty_mask_o,
  output cache_meta_pkg::lru_bits_t       lru_data_o,
  output cache_meta_pkg::lru_bits_t       lru_mask_o,
  output cache_meta_pkg::way_id_t         way_sel_o,
  output cache_meta_pkg::tag_t            addr_tag_o,
  output cache_op_pkg::dma_cmd_e          dma_cmd_o,
  output cache_meta_pkg::way_id_t         dma_way_o,
  output logic [`CM_ADDR_WIDTH-1:0]       dma_addr_o,
  output logic                            done_o,
  output logic                            done_hit_o,
  output cache_meta_pkg::way_id_t         done_way_o
);
  import cache_op_pkg::*;
  import cache_meta_pkg::*;

  localparam int BYTE_W = $clog2(`CM_WORD_BYTES);

  miss_state_e               state_r;
  miss_state_e               state_n;
  cache_op_e                 op_r;
  logic [`CM_ADDR_WIDTH-1:0] addr_r;
  way_id_t                   way_r;
  way_id_t                   way_n;
  logic                      hit_r;
  logic                      hit_n;
  set_idx_t                  index;
  way_vec_t                  way_onehot;
  logic                      is_flush;
  logic                      evict_needed;

  assign index = addr_r[BLOCK_OFFSET_W +: INDEX_W];
  assign addr_tag_o = addr_r[BLOCK_OFFSET_W + INDEX_W +: TAG_W];
  assign ready_o = (state_r == IDLE);
  assign rd_v_o = ready_o & req_v_i;
  assign set_o = ready_o ? req_addr_i[BLOCK_OFFSET_W +: INDEX_W] : index;
  assign way_sel_o = way_r;
  assign dma_way_o = way_r;
  assign done_hit_o = hit_r;
  assign done_way_o = way_r;
  assign tag_data_o = addr_tag_o;
  assign way_onehot = way_vec_t'(1) << way_r;
  assign is_flush = op_r inside {OP_AFL, OP_AINV, OP_AFLINV};
  assign evict_needed = dirty_i[way_r] & valid_i[way_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      way_r <= '0;
      hit_r <= 1'b0;
    end else begin
      state_r <= state_n;
      way_r <= way_n;
      hit_r <= hit_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_v_o) begin
      op_r <= req_op_i;
      addr_r <= req_addr_i;
    end
  end

  always_comb begin
    state_n = state_r;
    way_n = way_r;
    hit_n = hit_r;
    tag_we_o = 1'b0;
    lock_data_o = 1'b0;
    valid_data_o = 1'b0;
    tag_mask_o = '0;
    lock_mask_o = '0;
    valid_mask_o = '0;
    stat_we_o = 1'b0;
    dirty_data_o = 1'b0;
    dirty_mask_o = '0;
    lru_data_o = mru_data_i;
    lru_mask_o = mru_mask_i;
    dma_cmd_o = DMA_NOP;
    dma_addr_o = '0;
    done_o = 1'b0;

    case (state_r)
      IDLE: begin
        if (req_v_i) begin
          state_n = LOOKUP;
        end
      end

      // store data for the set is valid here; the way is fixed for the request.
      LOOKUP: begin
        hit_n = hit_i;
        way_n = hit_i ? hit_way_i : victim_way_i;
        if (is_flush || op_r == OP_AUNLOCK) begin
          if (!hit_i) begin
            state_n = DONE;
          end else begin
            state_n = is_flush ? FLUSH_OP : LOCK_OP;
          end
        end else if (hit_i) begin
          state_n = (op_r == OP_ALOCK) ? LOCK_OP : HIT_UPDATE;
        end else begin
          state_n = SEND_FILL_ADDR;
        end
      end

      HIT_UPDATE: begin
        stat_we_o = 1'b1;
        dirty_data_o = 1'b1;
        dirty_mask_o = (op_r == OP_ST) ? way_onehot : '0;
        state_n = DONE;
      end

      // dirty is cleared on every flush op; AINV and AFLINV also drop valid and lock.
      FLUSH_OP: begin
        stat_we_o = 1'b1;
        dirty_mask_o = way_onehot;
        lru_mask_o = '0;
        tag_we_o = 1'b1;
        if (op_r inside {OP_AINV, OP_AFLINV}) begin
          valid_mask_o = way_onehot;
          lock_mask_o = way_onehot;
        end
        state_n = (op_r != OP_AINV && evict_needed) ? SEND_EVICT_ADDR : DONE;
      end

      LOCK_OP: begin
        tag_we_o = 1'b1;
        lock_data_o = (op_r == OP_ALOCK);
        lock_mask_o = way_onehot;
        state_n = DONE;
      end

      SEND_FILL_ADDR: begin
        dma_cmd_o = DMA_SEND_FILL_ADDR;
        dma_addr_o = {addr_tag_o, index, {BLOCK_OFFSET_W{1'b0}}};
        if (dma_done_i) begin
          state_n = evict_needed ? SEND_EVICT_ADDR : GET_FILL_DATA;
        end
      end

      SEND_EVICT_ADDR: begin
        dma_cmd_o = DMA_SEND_EVICT_ADDR;
        dma_addr_o = {tags_i[way_r], index, {BLOCK_OFFSET_W{1'b0}}};
        if (dma_done_i) begin
          state_n = SEND_EVICT_DATA;
        end
      end

      SEND_EVICT_DATA: begin
        dma_cmd_o = DMA_SEND_EVICT_DATA;
        dma_addr_o = {tags_i[way_r], index, {BLOCK_OFFSET_W{1'b0}}};
        if (dma_done_i) begin
          state_n = is_flush ? DONE : GET_FILL_DATA;
        end
      end

      // the word offset rides along so the engine can return the missed word first.
      GET_FILL_DATA: begin
        dma_cmd_o = DMA_GET_FILL_DATA;
        dma_addr_o = {addr_r[`CM_ADDR_WIDTH-1:BYTE_W], {BYTE_W{1'b0}}};
        tag_we_o = dma_done_i;
        valid_data_o = 1'b1;
        lock_data_o = (op_r == OP_ALOCK);
        tag_mask_o = way_onehot;
        valid_mask_o = way_onehot;
        lock_mask_o = way_onehot;
        stat_we_o = dma_done_i;
        dirty_data_o = (op_r == OP_ST);
        dirty_mask_o = way_onehot;
        if (dma_done_i) begin
          state_n = DONE;
        end
      end

      DONE: begin
        done_o = 1'b1;
        if (ack_i) begin
          state_n = IDLE;
        end
      end

      default: begin
        state_n = IDLE;
      end
    endcase
  end

  // the DMA engine may sample the command late, so it must not move under it.
  assert property (@(posedge clk_i) disable iff (reset_i)
    (dma_cmd_o != DMA_NOP && !dma_done_i) |=>
      $stable(dma_cmd_o) && $stable(dma_way_o) && $stable(dma_addr_o));

endmodule

`default_nettype wire

/* design/cache_miss_top.sv */
/*
 * Miss handler top level.
 * Connects the metadata store, way selection and the FSM behind one
 * request port and one DMA command port.
 */
`timescale 1ns/1ps
`include "cache_miss_defines.svh"
`default_nettype none

module cache_miss_top (
  input  wire                          clk_i,
  input  wire                          reset_i,
  input  wire                          req_v_i,
  input  wire cache_op_pkg::cache_op_e req_op_i,
  input  wire [`CM_ADDR_WIDTH-1:0]     req_addr_i,
  output logic                         ready_o,
  output cache_op_pkg::dma_cmd_e       dma_cmd_o,
  output cache_meta_pkg::way_id_t      dma_way_o,
  output logic [`CM_ADDR_WIDTH-1:0]    dma_addr_o,
  input  wire                          dma_done_i,
  output logic                         done_o,
  output logic                         done_hit_o,
  output cache_meta_pkg::way_id_t      done_way_o,
  input  wire                          ack_i
);
  import cache_meta_pkg::*;

  logic       rd_v;
  set_idx_t   set_idx;
  logic       tag_we;
  tag_t       tag_data;
  logic       lock_data;
  logic       valid_data;
  way_vec_t   tag_mask;
  way_vec_t   lock_mask;
  way_vec_t   valid_mask;
  logic       stat_we;
  logic       dirty_data;
  way_vec_t   dirty_mask;
  lru_bits_t  lru_data;
  lru_bits_t  lru_mask;
  tag_array_t tags;
  way_vec_t   valid;
  way_vec_t   lock;
  way_vec_t   dirty;
  lru_bits_t  lru;
  logic       hit;
  way_id_t    hit_way;
  way_id_t    victim_way;
  lru_bits_t  mru_data;
  lru_bits_t  mru_mask;
  way_id_t    way_sel;
  tag_t       addr_tag;

  cache_meta_store u_store (
    .clk_i(clk_i), .reset_i(reset_i), .rd_v_i(rd_v), .set_i(set_idx),
    .tag_we_i(tag_we), .tag_data_i(tag_data), .lock_data_i(lock_data),
    .valid_data_i(valid_data), .tag_mask_i(tag_mask), .lock_mask_i(lock_mask),
    .valid_mask_i(valid_mask), .stat_we_i(stat_we), .dirty_data_i(dirty_data),
    .dirty_mask_i(dirty_mask), .lru_data_i(lru_data), .lru_mask_i(lru_mask),
    .tags_o(tags), .valid_o(valid), .lock_o(lock), .dirty_o(dirty), .lru_o(lru)
  );

  cache_way_select u_way_select (
    .clk_i(clk_i), .reset_i(reset_i), .addr_tag_i(addr_tag), .tags_i(tags),
    .valid_i(valid), .lock_i(lock), .lru_i(lru), .way_sel_i(way_sel),
    .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
    .mru_data_o(mru_data), .mru_mask_o(mru_mask)
  );

  cache_miss_fsm u_fsm (
    .clk_i(clk_i), .reset_i(reset_i), .req_v_i(req_v_i), .req_op_i(req_op_i),
    .req_addr_i(req_addr_i), .hit_i(hit), .hit_way_i(hit_way),
    .victim_way_i(victim_way), .mru_data_i(mru_data), .mru_mask_i(mru_mask),
    .tags_i(tags), .valid_i(valid), .dirty_i(dirty), .dma_done_i(dma_done_i),
    .ack_i(ack_i), .ready_o(ready_o), .rd_v_o(rd_v), .set_o(set_idx),
    .tag_we_o(tag_we), .tag_data_o(tag_data), .lock_data_o(lock_data),
    .valid_data_o(valid_data), .tag_mask_o(tag_mask), .lock_mask_o(lock_mask),
    .valid_mask_o(valid_mask), .stat_we_o(stat_we), .dirty_data_o(dirty_data),
    .dirty_mask_o(dirty_mask), .lru_data_o(lru_data), .lru_mask_o(lru_mask),
    .way_sel_o(way_sel), .addr_tag_o(addr_tag), .dma_cmd_o(dma_cmd_o),
    .dma_way_o(dma_way_o), .dma_addr_o(dma_addr_o), .done_o(done_o),
    .done_hit_o(done_hit_o), .done_way_o(done_way_o)
  );

endmodule

`default_nettype wire

/* design/cache_op_pkg.sv */
/*
 * Opcodes, DMA commands and miss handler states.
 * Shared by the requester side, the FSM and the testbench.
 */
`default_nettype none

package cache_op_pkg;

  // request opcodes seen on the request port.
  typedef enum logic [2:0] {
    OP_LD,
    OP_ST,
    OP_ALOCK,
    OP_AUNLOCK,
    OP_AFL,
    OP_AINV,
    OP_AFLINV
  } cache_op_e;

  // commands presented to the DMA engine.
  typedef enum logic [2:0] {
    DMA_NOP,
    DMA_SEND_FILL_ADDR,
    DMA_SEND_EVICT_ADDR,
    DMA_SEND_EVICT_DATA,
    DMA_GET_FILL_DATA
  } dma_cmd_e;

  typedef enum logic [3:0] {
    IDLE,
    LOOKUP,
    HIT_UPDATE,
    FLUSH_OP,
    LOCK_OP,
    SEND_FILL_ADDR,
    SEND_EVICT_ADDR,
    SEND_EVICT_DATA,
    GET_FILL_DATA,
    DONE
  } miss_state_e;

endpackage

`default_nettype wire

/* design/cache_way_select.sv */
/*
 * Hit detection and replacement choice for one set.
 * The victim is the lowest invalid, unlocked way, else the pseudo-LRU way
 * steered around locked subtrees. Also builds the MRU update for a way.
 */
`timescale 1ns/1ps
`include "cache_miss_defines.svh"
`default_nettype none

module cache_way_select (
  input  wire                             clk_i,
  input  wire                             reset_i,
  input  wire cache_meta_pkg::tag_t       addr_tag_i,
  input  wire cache_meta_pkg::tag_array_t tags_i,
  input  wire cache_meta_pkg::way_vec_t   valid_i,
  input  wire cache_meta_pkg::way_vec_t   lock_i,
  input  wire cache_meta_pkg::lru_bits_t  lru_i,
  input  wire cache_meta_pkg::way_id_t    way_sel_i,
  output logic                            hit_o,
  output cache_meta_pkg::way_id_t         hit_way_o,
  output cache_meta_pkg::way_id_t         victim_way_o,
  output cache_meta_pkg::lru_bits_t       mru_data_o,
  output cache_meta_pkg::lru_bits_t       mru_mask_o
);
  import cache_meta_pkg::*;

  way_vec_t match;
  way_vec_t free_ways;
  way_id_t  free_way;
  way_id_t  lru_way;

  // true when every way whose upper bits equal prefix is locked.
  function automatic logic subtree_locked(way_vec_t lock, int shift, int prefix);
    logic all_locked;
    all_locked = 1'b1;
    for (int w = 0; w < `CM_WAYS; w++) begin
      if ((w >> shift) == prefix) begin
        all_locked &= lock[w];
      end
    end
    return all_locked;
  endfunction

  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < `CM_WAYS; w++) begin
      match[w] = valid_i[w] && (tags_i[w] == addr_tag_i);
      if (match[w]) begin
        hit_way_o = way_id_t'(w);
      end
    end
  end

  assign hit_o = |match;
  assign free_ways = ~valid_i & ~lock_i;

  always_comb begin
    free_way = '0;
    for (int w = `CM_WAYS - 1; w >= 0; w--) begin
      if (free_ways[w]) begin
        free_way = way_id_t'(w);
      end
    end
  end

  // walk from the root and flip a node whose LRU half is entirely locked.
  always_comb begin
    int node;
    logic side;
    node = 0;
    lru_way = '0;
    for (int lvl = 0; lvl < WAY_ID_W; lvl++) begin
      side = lru_i[node];
      if (subtree_locked(lock_i, WAY_ID_W - lvl - 1, 2 * lru_way + side)) begin
        side = ~side;
      end
      lru_way = way_id_t'({lru_way, side});
      node = 2 * node + 1 + side;
    end
  end

  assign victim_way_o = (|free_ways) ? free_way : lru_way;

  // path nodes point away from the selected way so it becomes MRU.
  always_comb begin
    int node;
    logic branch;
    node = 0;
    mru_data_o = '0;
    mru_mask_o = '0;
    for (int lvl = 0; lvl < WAY_ID_W; lvl++) begin
      branch = way_sel_i[WAY_ID_W - 1 - lvl];
      mru_mask_o[node] = 1'b1;
      mru_data_o[node] = ~branch;
      node = 2 * node + 1 + branch;
    end
  end

  // a set with any unlocked way must never replace a locked line.
  assert property (@(posedge clk_i) disable iff (reset_i)
    (~lock_i != '0) |-> !lock_i[victim_way_o]);

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/cache_op_pkg.sv
design/cache_meta_pkg.sv
design/cache_meta_store.sv
design/cache_way_select.sv
design/cache_miss_fsm.sv
design/cache_miss_top.sv
tests/tb_cache_miss.sv

/* tests/miss_input.txt */
// op addr delay hit way ncmd, then four dma slots of cmd way addr; all hex, unused slots zero.
// op 0 LD 1 ST 2 ALOCK 3 AUNLOCK 4 AFL 5 AINV 6 AFLINV, cmd 1 FILL_A 2 EVICT_A 3 EVICT_D 4 FILL_D
0 264  1 0 0 2  1 0 260   4 0 264   0 0 0     0 0 0
0 468  0 0 1 2  1 1 460   4 1 468   0 0 0     0 0 0
0 66c  2 0 2 2  1 2 660   4 2 66c   0 0 0     0 0 0
0 873  1 0 3 2  1 3 860   4 3 870   0 0 0     0 0 0
1 47c  1 1 1 0  0 0 0     0 0 0     0 0 0     0 0 0
0 264  1 1 0 0  0 0 0     0 0 0     0 0 0     0 0 0
0 664  1 1 2 0  0 0 0     0 0 0     0 0 0     0 0 0
0 a64  c 0 1 4  1 1 a60   2 1 460   3 1 460   4 1 a64
2 860  1 1 3 0  0 0 0     0 0 0     0 0 0     0 0 0
0 c60  1 0 2 2  1 2 c60   4 2 c60   0 0 0     0 0 0
0 e60  0 0 0 2  1 0 e60   4 0 e60   0 0 0     0 0 0
0 1060 1 0 2 2  1 2 1060  4 2 1060  0 0 0     0 0 0
2 1060 1 1 2 0  0 0 0     0 0 0     0 0 0     0 0 0
0 e60  1 1 0 0  0 0 0     0 0 0     0 0 0     0 0 0
0 1260 1 0 1 2  1 1 1260  4 1 1260  0 0 0     0 0 0
3 860  1 1 3 0  0 0 0     0 0 0     0 0 0     0 0 0
0 1460 1 0 3 2  1 3 1460  4 3 1460  0 0 0     0 0 0
1 e68  1 1 0 0  0 0 0     0 0 0     0 0 0     0 0 0
4 e60  14 1 0 2 2 0 e60   3 0 e60   0 0 0     0 0 0
0 e64  1 1 0 0  0 0 0     0 0 0     0 0 0     0 0 0
5 1260 1 1 1 0  0 0 0     0 0 0     0 0 0     0 0 0
0 1660 1 0 1 2  1 1 1660  4 1 1660  0 0 0     0 0 0
1 1668 1 1 1 0  0 0 0     0 0 0     0 0 0     0 0 0
5 1660 1 1 1 0  0 0 0     0 0 0     0 0 0     0 0 0
0 1664 1 0 1 2  1 1 1660  4 1 1664  0 0 0     0 0 0
1 1460 1 1 3 0  0 0 0     0 0 0     0 0 0     0 0 0
6 1460 1 1 3 2  2 3 1460  3 3 1460  0 0 0     0 0 0
0 1478 1e 0 3 2 1 3 1460  4 3 1478  0 0 0     0 0 0
2 1860 1 0 0 2  1 0 1860  4 0 1860  0 0 0     0 0 0
ff

/* tests/tb_cache_miss.sv */
/*
 * Testbench for the cache miss handler.
 * Replays the requests listed in the input file, answers each DMA command
 * after the listed delay plus a small jitter, and checks hit, way and the
 * order of DMA commands against the expected values in the file.
 */
`timescale 1ns/1ps
`include "cache_miss_defines.svh"
`default_nettype none

module tb_cache_miss;
  import cache_op_pkg::*;
  import cache_meta_pkg::*;

  // one record is op, addr, delay, hit, way, count, then four (cmd, way, addr) slots.
  localparam int REC_WORDS = 18;
  localparam int MAX_REQS = 64;
  localparam int MAX_CMDS = 4;
  localparam int TIMEOUT = 200;
  localparam logic [31:0] END_MARK = 32'hff;

  logic                      clk_i = 1'b0;
  logic                      reset_i;
  logic                      req_v_i;
  cache_op_e                 req_op_i;
  logic [`CM_ADDR_WIDTH-1:0] req_addr_i;
  logic                      ready_o;
  dma_cmd_e                  dma_cmd_o;
  way_id_t                   dma_way_o;
  logic [`CM_ADDR_WIDTH-1:0] dma_addr_o;
  logic                      dma_done_i;
  logic                      done_o;
  logic                      done_hit_o;
  way_id_t                   done_way_o;
  logic                      ack_i;

  logic [31:0] stim [REC_WORDS * MAX_REQS];
  integer      seed = 32'haa62_5eb6;
  int          errors;
  int          checks;
  int          req_num;
  int          req_errors;
  logic        timed_out;

  cache_miss_top DUT (
    .clk_i(clk_i), .reset_i(reset_i), .req_v_i(req_v_i), .req_op_i(req_op_i),
    .req_addr_i(req_addr_i), .ready_o(ready_o), .dma_cmd_o(dma_cmd_o),
    .dma_way_o(dma_way_o), .dma_addr_o(dma_addr_o), .dma_done_i(dma_done_i),
    .done_o(done_o), .done_hit_o(done_hit_o), .done_way_o(done_way_o), .ack_i(ack_i)
  );

  always #50 clk_i = ~clk_i;

  task automatic note_failure(input string what);
    $display("request %0d: %s", req_num, what);
    errors++;
    req_errors++;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error: %s = %h, expected %h (request %0d)", name, got, exp, req_num);
      errors++;
      req_errors++;
    end
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!ready_o && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (ready_o) else begin
      note_failure("timeout, ready_o stayed low for 200 cycles");
      timed_out = 1'b1;
    end
  endtask

  // returns on the first cycle that shows a DMA command or the done level.
  task automatic wait_dma_or_done();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (dma_cmd_o == DMA_NOP && !done_o && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (dma_cmd_o != DMA_NOP || done_o) else begin
      note_failure("timeout, neither a DMA command nor done_o within 200 cycles");
      timed_out = 1'b1;
    end
  endtask

  task automatic answer_dma(input int base, input int k);
    dma_cmd_e    cmd;
    way_id_t     way;
    logic [31:0] addr;
    int          delay;
    cmd = dma_cmd_o;
    way = dma_way_o;
    addr = dma_addr_o;
    assert (k < MAX_CMDS) else note_failure("more DMA commands than the trace allows");
    if (k < MAX_CMDS) begin
      check_value("dma_cmd_o", cmd, stim[base + 6 + 3 * k]);
      check_value("dma_way_o", way, stim[base + 7 + 3 * k]);
      check_value("dma_addr_o", addr, stim[base + 8 + 3 * k]);
    end
    delay = stim[base + 2] + {$random(seed)} % 3;
    repeat (delay) @(negedge clk_i);
    // a busy engine stretches the state while the command holds still.
    check_value("dma_cmd_o", dma_cmd_o, cmd);
    check_value("dma_addr_o", dma_addr_o, addr);
    @(posedge clk_i);
    dma_done_i <= 1'b1;
    @(posedge clk_i);
    dma_done_i <= 1'b0;
  endtask

  task automatic run_request(input int base);
    cache_op_e   op;
    logic [31:0] addr;
    int          seen;
    logic        done_seen;
    op = cache_op_e'(stim[base][2:0]);
    addr = stim[base + 1];
    seen = 0;
    done_seen = 1'b0;
    req_errors = 0;
    wait_ready();
    if (!timed_out) begin
      @(posedge clk_i);
      req_v_i <= 1'b1;
      req_op_i <= op;
      req_addr_i <= addr;
      @(posedge clk_i);
      req_v_i <= 1'b0;
    end
    while (!done_seen && !timed_out && seen <= MAX_CMDS) begin
      wait_dma_or_done();
      if (!timed_out && done_o) begin
        done_seen = 1'b1;
      end else if (!timed_out) begin
        answer_dma(base, seen);
        seen++;
      end
    end
    if (done_seen) begin
      check_value("done_hit_o", done_hit_o, stim[base + 3]);
      check_value("done_way_o", done_way_o, stim[base + 4]);
      assert (seen == stim[base + 5]) else
        note_failure($sformatf("%0d DMA commands seen, %0d expected", seen, stim[base + 5]));
      // done_o is a level and holds until the acknowledge.
      @(negedge clk_i);
      check_value("done_o", done_o, 32'd1);
      @(posedge clk_i);
      ack_i <= 1'b1;
      @(posedge clk_i);
      ack_i <= 1'b0;
      @(negedge clk_i);
      check_value("ready_o", ready_o, 32'd1);
    end
    $display("request %0d %s addr %h: %s", req_num, op.name(), addr,
             (req_errors == 0) ? "ok" : "mismatch");
  endtask

  initial begin
    int base;
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_op_i = OP_LD;
    req_addr_i = '0;
    dma_done_i = 1'b0;
    ack_i = 1'b0;
    errors = 0;
    checks = 0;
    req_num = 0;
    req_errors = 0;
    timed_out = 1'b0;
    $readmemh("tests/miss_input.txt", stim);

    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("ready_o", ready_o, 32'd1);
    check_value("done_o", done_o, 32'd0);
    check_value("dma_cmd_o", dma_cmd_o, DMA_NOP);

    base = 0;
    while (base < REC_WORDS * MAX_REQS && !$isunknown(stim[base])
           && stim[base] != END_MARK && !timed_out) begin
      req_num++;
      run_request(base);
      base += REC_WORDS;
    end
    assert (req_num > 0) else note_failure("no requests were read from the input file");

    $display("%0d requests, %0d checks, %0d errors", req_num, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
